// File: rtl/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath word width
`define WORD_W 32

// register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// JAL destination
`define LINK_REG 31

`endif

// File: rtl/mipsPkg.sv
package mipsPkg;

	// one instruction word, two field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm16;
		} iType;
	} instrWordT;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_JAL     = 6'h03,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f
	} opcodeE;

	// funct field of SPECIAL
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} functE;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpE;

	// IMM is the already shifted LUI value
	typedef enum logic [1:0] {
		RES_ALU,
		RES_IMM,
		RES_LINK
	} resultSelE;

	typedef enum logic {
		B_RT,
		B_IMM
	} bSelE;

endpackage

// File: rtl/idExIf.sv
`include "mips_config.svh"

interface idExIf;
	import mipsPkg::*;

	logic valid;
	logic regWrite;
	logic [`REG_ADDR_W-1:0] destAddr;
	logic [`REG_ADDR_W-1:0] rsAddr;
	logic [`REG_ADDR_W-1:0] rtAddr;
	logic [`WORD_W-1:0] rsData;
	logic [`WORD_W-1:0] rtData;
	logic [`WORD_W-1:0] imm32;
	logic [`WORD_W-1:0] pc;
	aluOpE aluOp;
	bSelE bSel;
	resultSelE resultSel;

	modport decode (
		output valid, regWrite, destAddr, rsAddr, rtAddr,
		output rsData, rtData, imm32, pc,
		output aluOp, bSel, resultSel
	);

	modport execute (
		input valid, regWrite, destAddr, rsAddr, rtAddr,
		input rsData, rtData, imm32, pc,
		input aluOp, bSel, resultSel
	);

endinterface

// File: rtl/regFile.sv
`include "mips_config.svh"

module regFile (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic [`REG_ADDR_W-1:0] raddrA,
	input  logic [`REG_ADDR_W-1:0] raddrB,
	input  logic                   wen,
	input  logic [`REG_ADDR_W-1:0] waddr,
	input  logic [`WORD_W-1:0]     wdata,
	output logic [`WORD_W-1:0]     rdataA,
	output logic [`WORD_W-1:0]     rdataB
);

	logic [`WORD_W-1:0] regs [`REG_COUNT];

	// r0 reads zero and a same-cycle write passes straight through
	function automatic logic [`WORD_W-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wen && waddr == addr)
			return wdata;
		else
			return regs[addr];
	endfunction

	always_comb begin
		rdataA = readPort(raddrA);
		rdataB = readPort(raddrB);
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	aWriteKnown: assert property (
		@(posedge clk) disable iff (!arstN)
		wen |-> !$isunknown({waddr, wdata})
	);

endmodule

// File: rtl/instrDecode.sv
`include "mips_config.svh"

module instrDecode (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   issueValid,
	input  mipsPkg::instrWordT     instr,
	input  logic [`WORD_W-1:0]     pc,
	output logic [`REG_ADDR_W-1:0] raddrA,
	output logic [`REG_ADDR_W-1:0] raddrB,
	input  logic [`WORD_W-1:0]     rdataA,
	input  logic [`WORD_W-1:0]     rdataB,
	idExIf.decode                  idEx
);
	import mipsPkg::*;

	logic regWriteD;
	logic [`REG_ADDR_W-1:0] destD;
	logic [`WORD_W-1:0] immD;
	aluOpE aluOpD;
	bSelE bSelD;
	resultSelE resSelD;

	assign raddrA = instr.rType.rs;
	assign raddrB = instr.rType.rt;

	always_comb begin
		regWriteD = 1'b0;
		destD = instr.iType.rt;
		immD = {{16{instr.iType.imm16[15]}}, instr.iType.imm16};
		aluOpD = ALU_ADD;
		bSelD = B_RT;
		resSelD = RES_ALU;
		case (instr.rType.opcode)
			OP_SPECIAL: begin
				destD = instr.rType.rd;
				regWriteD = 1'b1;
				case (instr.rType.funct)
					FN_ADDU: aluOpD = ALU_ADD;
					FN_SUBU: aluOpD = ALU_SUB;
					FN_AND:  aluOpD = ALU_AND;
					FN_OR:   aluOpD = ALU_OR;
					FN_SLT:  aluOpD = ALU_SLT;
					default: regWriteD = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				regWriteD = 1'b1;
				bSelD = B_IMM;
			end
			OP_ORI: begin
				// logical immediates are zero extended
				regWriteD = 1'b1;
				immD = {16'h0000, instr.iType.imm16};
				aluOpD = ALU_OR;
				bSelD = B_IMM;
			end
			OP_LUI: begin
				regWriteD = 1'b1;
				immD = {instr.iType.imm16, 16'h0000};
				resSelD = RES_IMM;
			end
			OP_JAL: begin
				regWriteD = 1'b1;
				destD = `REG_ADDR_W'(`LINK_REG);
				resSelD = RES_LINK;
			end
			default: begin
				regWriteD = 1'b0;
			end
		endcase
	end

	// ID/EX control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx.valid <= 1'b0;
			idEx.regWrite <= 1'b0;
		end else begin
			idEx.valid <= issueValid;
			idEx.regWrite <= issueValid & regWriteD;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		if (issueValid) begin
			idEx.destAddr <= destD;
			idEx.rsAddr <= raddrA;
			idEx.rtAddr <= raddrB;
			idEx.rsData <= rdataA;
			idEx.rtData <= rdataB;
			idEx.imm32 <= immD;
			idEx.pc <= pc;
			idEx.aluOp <= aluOpD;
			idEx.bSel <= bSelD;
			idEx.resultSel <= resSelD;
		end
	end

	aValidKnown: assert property (
		@(posedge clk) disable iff (!arstN)
		!$isunknown(idEx.valid)
	);

endmodule

// File: rtl/exStage.sv
`include "mips_config.svh"

module exStage (
	idExIf.execute                 idEx,
	input  logic                   clk,
	input  logic                   arstN,
	output logic                   wen,
	output logic [`REG_ADDR_W-1:0] waddr,
	output logic [`WORD_W-1:0]     wdata
);
	import mipsPkg::*;

	logic [`WORD_W-1:0] opA;
	logic [`WORD_W-1:0] rtFwd;
	logic [`WORD_W-1:0] opB;
	logic [`WORD_W-1:0] aluOut;
	logic [`WORD_W-1:0] result;
	logic sltBit;

	// take the EX/WB result when it targets this source
	function automatic logic [`WORD_W-1:0] fwdSel(
		input logic [`REG_ADDR_W-1:0] srcAddr,
		input logic [`WORD_W-1:0]     srcData
	);
		if (wen && waddr != '0 && waddr == srcAddr)
			return wdata;
		else
			return srcData;
	endfunction

	always_comb begin
		opA = fwdSel(idEx.rsAddr, idEx.rsData);
		rtFwd = fwdSel(idEx.rtAddr, idEx.rtData);
	end

	always_comb begin
		case (idEx.bSel)
			B_RT:    opB = rtFwd;
			default: opB = idEx.imm32;
		endcase
	end

	// signed compare for SLT
	assign sltBit = $signed(opA) < $signed(opB);

	always_comb begin
		case (idEx.aluOp)
			ALU_ADD: aluOut = opA + opB;
			ALU_SUB: aluOut = opA - opB;
			ALU_AND: aluOut = opA & opB;
			ALU_OR:  aluOut = opA | opB;
			ALU_SLT: aluOut = {{(`WORD_W-1){1'b0}}, sltBit};
			default: aluOut = '0;
		endcase
	end

	always_comb begin
		case (idEx.resultSel)
			RES_IMM:  result = idEx.imm32;
			RES_LINK: result = idEx.pc + `WORD_W'(8);
			default:  result = aluOut;
		endcase
	end

	// EX/WB control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			wen <= 1'b0;
		else
			wen <= idEx.valid & idEx.regWrite;
	end

	// EX/WB payload
	always_ff @(posedge clk) begin
		if (idEx.valid) begin
			waddr <= idEx.destAddr;
			wdata <= result;
		end
	end

	aAluOpKnown: assert property (
		@(posedge clk) disable iff (!arstN)
		idEx.valid |-> !$isunknown(idEx.aluOp)
	);

endmodule

// File: rtl/mipsDatapath.sv
`include "mips_config.svh"

module mipsDatapath (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   issueValid,
	input  logic [`WORD_W-1:0]     instr,
	input  logic [`WORD_W-1:0]     pc,
	output logic                   wbValid,
	output logic [`REG_ADDR_W-1:0] wbAddr,
	output logic [`WORD_W-1:0]     wbData
);

	logic [`REG_ADDR_W-1:0] raddrA;
	logic [`REG_ADDR_W-1:0] raddrB;
	logic [`WORD_W-1:0] rdataA;
	logic [`WORD_W-1:0] rdataB;

	idExIf idEx ();

	instrDecode decode0 (
		.clk        (clk),
		.arstN      (arstN),
		.issueValid (issueValid),
		.instr      (instr),
		.pc         (pc),
		.raddrA     (raddrA),
		.raddrB     (raddrB),
		.rdataA     (rdataA),
		.rdataB     (rdataB),
		.idEx       (idEx.decode)
	);

	// writeback bus doubles as the top-level report
	exStage ex0 (
		.idEx  (idEx.execute),
		.clk   (clk),
		.arstN (arstN),
		.wen   (wbValid),
		.waddr (wbAddr),
		.wdata (wbData)
	);

	// r0 writes are reported above but dropped here
	regFile regs0 (
		.clk    (clk),
		.arstN  (arstN),
		.raddrA (raddrA),
		.raddrB (raddrB),
		.wen    (wbValid),
		.waddr  (wbAddr),
		.wdata  (wbData),
		.rdataA (rdataA),
		.rdataB (rdataB)
	);

endmodule

// File: verification/tbClock.sv
module tbClock (
	output logic clk,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_NS = 5;
	localparam int RESET_CYCLES = 3;

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	// release reset away from the rising edge
	initial begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

endmodule

// File: verification/tbMipsDatapath.sv
`include "mips_config.svh"

module tbMipsDatapath;
	timeunit 1ns;
	timeprecision 100ps;
	import mipsPkg::*;

	localparam int RAND_SLOTS = 200;
	localparam int SLACK_CYCLES = 20;
	localparam int CLK_NS = 10;

	typedef struct packed {
		logic valid;
		logic [`REG_ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] data;
	} wbExpT;

	typedef struct packed {
		logic issue;
		logic [`WORD_W-1:0] instr;
		logic [`WORD_W-1:0] pc;
		wbExpT exp;
	} stepT;

	logic clk;
	logic arstN;
	logic issueValid;
	logic [`WORD_W-1:0] instr;
	logic [`WORD_W-1:0] pc;
	logic wbValid;
	logic [`REG_ADDR_W-1:0] wbAddr;
	logic [`WORD_W-1:0] wbData;

	stepT steps[$];
	wbExpT expQ[$];
	logic [`WORD_W-1:0] refRegs [`REG_COUNT];
	logic [`WORD_W-1:0] pcNext;
	logic [31:0] rngState;
	int tableLen = 0;

	tbClock clkGen0 (
		.clk   (clk),
		.arstN (arstN)
	);

	mipsDatapath dut0 (
		.clk        (clk),
		.arstN      (arstN),
		.issueValid (issueValid),
		.instr      (instr),
		.pc         (pc),
		.wbValid    (wbValid),
		.wbAddr     (wbAddr),
		.wbData     (wbData)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [`WORD_W-1:0] encR(input logic [5:0] fn,
			input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
		instrWordT w;
		w.rType.opcode = OP_SPECIAL;
		w.rType.rs = rs;
		w.rType.rt = rt;
		w.rType.rd = rd;
		w.rType.shamt = 5'd0;
		w.rType.funct = fn;
		return w;
	endfunction

	function automatic logic [`WORD_W-1:0] encI(input logic [5:0] op,
			input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		instrWordT w;
		w.iType.opcode = op;
		w.iType.rs = rs;
		w.iType.rt = rt;
		w.iType.imm16 = imm;
		return w;
	endfunction

	function automatic logic [`WORD_W-1:0] encJal(input logic [25:0] target);
		return {OP_JAL, target};
	endfunction

	task automatic addIssue(input logic [`WORD_W-1:0] iw, input logic wv,
			input logic [4:0] wa, input logic [`WORD_W-1:0] wd);
		stepT s;
		s.issue = 1'b1;
		s.instr = iw;
		s.pc = pcNext;
		s.exp.valid = wv;
		s.exp.addr = wa;
		s.exp.data = wd;
		steps.push_back(s);
		pcNext = pcNext + 32'd4;
	endtask

	task automatic addIdle();
		stepT s;
		s = '0;
		steps.push_back(s);
	endtask

	// expected values worked out by hand from the ISA
	task automatic buildTable();
		addIdle();
		addIdle();
		addIssue(encI(OP_ADDIU, 5'd0, 5'd1, 16'h0005), 1'b1, 5'd1, 32'h0000_0005);
		addIssue(encI(OP_ADDIU, 5'd0, 5'd2, 16'hfffd), 1'b1, 5'd2, 32'hffff_fffd);
		addIssue(encI(OP_ORI, 5'd0, 5'd3, 16'h8001), 1'b1, 5'd3, 32'h0000_8001);
		addIssue(encI(OP_LUI, 5'd0, 5'd4, 16'h1234), 1'b1, 5'd4, 32'h1234_0000);
		// rs straight from EX/WB and rt through write-through
		addIssue(encR(FN_ADDU, 5'd4, 5'd3, 5'd5), 1'b1, 5'd5, 32'h1234_8001);
		addIssue(encR(FN_SUBU, 5'd5, 5'd1, 5'd6), 1'b1, 5'd6, 32'h1234_7ffc);
		// both sources forwarded
		addIssue(encR(FN_ADDU, 5'd6, 5'd6, 5'd7), 1'b1, 5'd7, 32'h2468_fff8);
		addIssue(encR(FN_AND, 5'd7, 5'd3, 5'd8), 1'b1, 5'd8, 32'h0000_8000);
		addIssue(encR(FN_OR, 5'd1, 5'd8, 5'd9), 1'b1, 5'd9, 32'h0000_8005);
		addIssue(encR(FN_SLT, 5'd2, 5'd1, 5'd10), 1'b1, 5'd10, 32'h0000_0001);
		addIssue(encR(FN_SLT, 5'd1, 5'd2, 5'd11), 1'b1, 5'd11, 32'h0000_0000);
		addIssue(encI(OP_ADDIU, 5'd0, 5'd12, 16'h0100), 1'b1, 5'd12, 32'h0000_0100);
		addIssue(encI(OP_ORI, 5'd0, 5'd13, 16'h0007), 1'b1, 5'd13, 32'h0000_0007);
		// r12 two ahead and r13 one ahead
		addIssue(encR(FN_ADDU, 5'd12, 5'd13, 5'd14), 1'b1, 5'd14, 32'h0000_0107);
		// issued at pc 0x00400038
		addIssue(encJal(26'h0001234), 1'b1, 5'd31, 32'h0040_0040);
		addIssue(encI(OP_ADDIU, 5'd31, 5'd15, 16'h0004), 1'b1, 5'd15, 32'h0040_0044);
		// r0 write still shows up on the writeback bus
		addIssue(encI(OP_ADDIU, 5'd1, 5'd0, 16'h0009), 1'b1, 5'd0, 32'h0000_000e);
		addIssue(encR(FN_ADDU, 5'd0, 5'd1, 5'd16), 1'b1, 5'd16, 32'h0000_0005);
		addIssue(encR(FN_OR, 5'd0, 5'd0, 5'd17), 1'b1, 5'd17, 32'h0000_0000);
		addIssue(encI(6'h3f, 5'd1, 5'd2, 16'h1234), 1'b0, 5'd0, 32'h0000_0000);
		addIssue(encR(6'h00, 5'd1, 5'd2, 5'd3), 1'b0, 5'd0, 32'h0000_0000);
		addIdle();
		addIssue(encR(FN_ADDU, 5'd10, 5'd11, 5'd18), 1'b1, 5'd18, 32'h0000_0001);
		addIssue(encI(OP_ADDIU, 5'd2, 5'd19, 16'hfffe), 1'b1, 5'd19, 32'hffff_fffb);
		addIssue(encI(OP_ORI, 5'd4, 5'd20, 16'h00ff), 1'b1, 5'd20, 32'h1234_00ff);
	endtask

	// architectural reference for the random program
	task automatic modelExec(input logic [`WORD_W-1:0] raw, input logic [`WORD_W-1:0] ipc,
			output wbExpT e);
		instrWordT iw;
		logic [`WORD_W-1:0] a;
		logic [`WORD_W-1:0] b;
		logic [`WORD_W-1:0] sImm;
		logic [`WORD_W-1:0] zImm;
		iw = raw;
		a = refRegs[iw.rType.rs];
		b = refRegs[iw.rType.rt];
		sImm = {{16{iw.iType.imm16[15]}}, iw.iType.imm16};
		zImm = {16'h0000, iw.iType.imm16};
		e = '0;
		e.valid = 1'b1;
		e.addr = iw.iType.rt;
		case (iw.rType.opcode)
			OP_SPECIAL: begin
				e.addr = iw.rType.rd;
				case (iw.rType.funct)
					FN_ADDU: e.data = a + b;
					FN_SUBU: e.data = a - b;
					FN_AND:  e.data = a & b;
					FN_OR:   e.data = a | b;
					FN_SLT:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: e = '0;
				endcase
			end
			OP_ADDIU: e.data = a + sImm;
			OP_ORI:   e.data = a | zImm;
			OP_LUI:   e.data = {iw.iType.imm16, 16'h0000};
			OP_JAL: begin
				e.addr = `REG_ADDR_W'(`LINK_REG);
				e.data = ipc + 32'd8;
			end
			default: e = '0;
		endcase
	endtask

	task automatic modelCommit(input wbExpT e);
		if (e.valid && e.addr != '0)
			refRegs[e.addr] = e.data;
	endtask

	task automatic stopWithFail(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic checkWriteback(input wbExpT e);
		assert (wbValid === e.valid) else
			stopWithFail($sformatf("error: at %0d ns: wbValid is %b, expected %b",
				$time, wbValid, e.valid));
		if (e.valid) begin
			assert (wbAddr === e.addr) else
				stopWithFail($sformatf("error: at %0d ns: wbAddr is %0d, expected %0d",
					$time, wbAddr, e.addr));
			assert (wbData === e.data) else
				stopWithFail($sformatf("error: at %0d ns: wbData is %h, expected %h",
					$time, wbData, e.data));
		end
	endtask

	// check the slot from two cycles back and drive the next one
	task automatic applySlot(input logic issue, input logic [`WORD_W-1:0] iw,
			input logic [`WORD_W-1:0] ipc, input wbExpT e);
		if (expQ.size() == 2)
			checkWriteback(expQ.pop_front());
		issueValid = issue;
		instr = iw;
		pc = ipc;
		expQ.push_back(e);
		@(negedge clk);
	endtask

	task automatic runRandom();
		logic [31:0] r;
		logic [31:0] k;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		logic [`WORD_W-1:0] iw;
		wbExpT e;
		for (int n = 0; n < RAND_SLOTS; n++) begin
			rngState = xorshift(rngState);
			r = rngState;
			rngState = xorshift(rngState);
			k = rngState;
			// few registers so that dependencies are frequent
			rs = {2'b00, r[6:4]};
			rt = {2'b00, r[9:7]};
			rd = {2'b00, r[12:10]};
			imm = r[28:13];
			case (k % 32'd9)
				32'd0:   iw = encR(FN_ADDU, rs, rt, rd);
				32'd1:   iw = encR(FN_SUBU, rs, rt, rd);
				32'd2:   iw = encR(FN_AND, rs, rt, rd);
				32'd3:   iw = encR(FN_OR, rs, rt, rd);
				32'd4:   iw = encR(FN_SLT, rs, rt, rd);
				32'd5:   iw = encI(OP_ADDIU, rs, rt, imm);
				32'd6:   iw = encI(OP_ORI, rs, rt, imm);
				32'd7:   iw = encI(OP_LUI, rs, rt, imm);
				default: iw = encJal(k[31:6]);
			endcase
			if (r[31:29] == 3'b000) begin
				e = '0;
				applySlot(1'b0, iw, pcNext, e);
			end else begin
				modelExec(iw, pcNext, e);
				modelCommit(e);
				applySlot(1'b1, iw, pcNext, e);
				pcNext = pcNext + 32'd4;
			end
		end
	endtask

	initial begin
		issueValid = 1'b0;
		instr = '0;
		pc = '0;
		rngState = 32'hb34823b9;
		pcNext = 32'h0040_0000;
		for (int i = 0; i < `REG_COUNT; i++)
			refRegs[i] = '0;
		buildTable();
		tableLen = steps.size();
		@(posedge arstN);
		foreach (steps[i]) begin
			if (steps[i].issue)
				modelCommit(steps[i].exp);
			applySlot(steps[i].issue, steps[i].instr, steps[i].pc, steps[i].exp);
		end
		runRandom();
		// drain the last two writebacks
		applySlot(1'b0, '0, '0, '0);
		applySlot(1'b0, '0, '0, '0);
		$display("Simulation finished: PASS");
		$finish;
	end

	initial begin
		wait (tableLen != 0);
		#((tableLen + RAND_SLOTS + SLACK_CYCLES) * CLK_NS);
		stopWithFail("timeout: the run hung and never reached the end of the test");
	end

endmodule

// File: project.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/idExIf.sv
rtl/regFile.sv
rtl/instrDecode.sv
rtl/exStage.sv
rtl/mipsDatapath.sv
verification/tbClock.sv
verification/tbMipsDatapath.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps
TOP = tbMipsDatapath
FILELIST = project.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
